// ==== hw/com_pkg.sv ====
package com_pkg;

    // =========================================================================
    // Address and length widths
    // =========================================================================

    localparam int addr_w = 15;  // Word address into the transmit RAM.
    localparam int len_w  = 13;  // Block word count.

    // =========================================================================
    // Block types and lengths
    // =========================================================================

    localparam logic [3:0] btype_info = 4'h1;
    localparam logic [3:0] btype_data = 4'hE;

    localparam logic [len_w-1:0] info_len     = 13'd14;  // Fixed size of an info block.
    localparam logic [len_w-1:0] data_hdr_len = 13'd8;   // Block header ahead of the payload.

    // =========================================================================
    // Region table
    // =========================================================================

    // Entry 0 is the info region, entries 1 to 6 are data regions 0 to 5.
    localparam int n_regions    = 7;
    localparam int region_info  = 0;
    localparam int region_data0 = 1;

    localparam logic [addr_w-1:0] region_default [n_regions] = '{
        15'h0100,
        15'h1000,
        15'h2200,
        15'h3400,
        15'h4600,
        15'h5800,
        15'h6A00
    };

endpackage

// ==== hw/eth_pkg.sv ====
package eth_pkg;

    // =========================================================================
    // Output frame format
    // =========================================================================

    // Width of the output stream and of every RAM word.
    localparam int word_w = 16;

    // Header word 0 is {frame_tag, btype, didx}.
    // Header word 1 is the payload word count, zero extended.
    localparam logic [7:0] frame_tag = 8'hA5;

    // Number of header beats ahead of the payload.
    localparam int hdr_words = 2;

endpackage

// ==== hw/frame_req_if.sv ====
`timescale 1ns/10ps

interface frame_req_if import com_pkg::*; ();

    logic              start;  // Level, high for the whole frame request.
    logic              done;   // One-cycle pulse on the last beat.
    logic [addr_w-1:0] base;   // First RAM word of the payload.
    logic [len_w-1:0]  len;    // Payload word count.
    logic [3:0]        btype;
    logic [3:0]        didx;

    // The request side holds base, len, btype and didx while start is high.
    modport src (
        output start,
        output base,
        output len,
        output btype,
        output didx,
        input  done
    );

    modport dst (
        input  start,
        input  base,
        input  len,
        input  btype,
        input  didx,
        output done
    );

endinterface

// ==== hw/send_region_regs.sv ====
`timescale 1ns/10ps

module send_region_regs import com_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              cfg_we,
    input  logic [2:0]        cfg_idx,
    input  logic [addr_w-1:0] cfg_base,

    output logic [addr_w-1:0] region_base [n_regions]
);

    logic idx_ok;

    // Index 7 has no entry behind it, so such writes are dropped.
    assign idx_ok = (cfg_idx < 3'(n_regions));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < n_regions; i++) begin
                region_base[i] <= region_default[i];
            end
        end else if (cfg_we && idx_ok) begin
            region_base[cfg_idx] <= cfg_base;
        end
    end

endmodule

// ==== hw/com_send.sv ====
`timescale 1ns/10ps

module com_send import com_pkg::*; (
    input  logic              clk,
    input  logic              rst,

    input  logic              fs,
    output logic              fd,

    input  logic [3:0]        btype,
    input  logic [3:0]        didx,
    input  logic [len_w-1:0]  dlen,

    input  logic [addr_w-1:0] region_base [n_regions],

    frame_req_if.src          req
);

    // One-hot states.
    localparam logic [4:0] st_idle = 5'h01;
    localparam logic [4:0] st_wait = 5'h02;
    localparam logic [4:0] st_take = 5'h04;
    localparam logic [4:0] st_work = 5'h08;
    localparam logic [4:0] st_done = 5'h10;

    logic [4:0]        state;
    logic [4:0]        next_state;
    logic [2:0]        data_slot;
    logic [addr_w-1:0] sel_base;
    logic [len_w-1:0]  sel_len;

    assign req.start = (state == st_work);
    assign fd        = (state == st_done);

    // =========================================================================
    // Request FSM
    // =========================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            st_idle: next_state = st_wait;
            st_wait: next_state = fs ? st_take : st_wait;
            st_take: next_state = st_work;
            st_work: next_state = req.done ? st_done : st_work;
            st_done: next_state = fs ? st_done : st_idle;  // Hold fd until the host lets go.
            default: next_state = st_idle;
        endcase
    end

    // =========================================================================
    // Region and count selection
    // =========================================================================

    assign data_slot = didx[2:0] + 3'(region_data0);  // Data regions follow the info entry.

    always_comb begin
        sel_base = '0;
        sel_len  = '0;
        if (btype == btype_info) begin
            sel_base = region_base[region_info];
            sel_len  = info_len;
        end else if (btype == btype_data && didx < 4'(n_regions - region_data0)) begin
            sel_base = region_base[data_slot];
            sel_len  = dlen + data_hdr_len;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req.base <= '0;
            req.len  <= '0;
        end else if (state == st_take) begin
            req.base <= sel_base;
            req.len  <= sel_len;
        end else if (state == st_done) begin
            req.base <= '0;
            req.len  <= '0;
        end
    end

    // Header fields for the frame streamer.
    always_ff @(posedge clk) begin
        if (state == st_take) begin
            req.btype <= btype;
            req.didx  <= didx;
        end
    end

endmodule

// ==== hw/eth_frame_tx.sv ====
`timescale 1ns/10ps

module eth_frame_tx import com_pkg::*, eth_pkg::*; #(
    parameter int ram_addr_w = addr_w
) (
    input  logic                  clk,
    input  logic                  rst,

    frame_req_if.dst              req,

    output logic                  rd_en,
    output logic [ram_addr_w-1:0] rd_addr,
    input  logic [word_w-1:0]     rd_data,

    output logic                  tx_valid,
    output logic [word_w-1:0]     tx_data,
    output logic                  tx_last
);

    logic                  start_d;
    logic                  launch;
    logic                  busy;
    logic [len_w:0]        beat;      // One bit wider than len to hold len plus the header.
    logic [len_w:0]        last_idx;
    logic                  last_beat;
    logic [ram_addr_w-1:0] rd_ptr;
    logic [word_w-1:0]     hdr_word;

    // =========================================================================
    // Launch and beat counter
    // =========================================================================

    assign launch    = req.start && !start_d;
    assign last_idx  = {1'b0, req.len} + (len_w + 1)'(hdr_words - 1);
    assign last_beat = (beat == last_idx);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_d <= 1'b0;
            busy    <= 1'b0;
            beat    <= '0;
        end else begin
            start_d <= req.start;
            if (launch) begin
                busy <= 1'b1;
                beat <= '0;
            end else if (busy) begin
                busy <= !last_beat;
                beat <= beat + 1'b1;
            end
        end
    end

    // =========================================================================
    // RAM read, one beat ahead of the output register
    // =========================================================================

    // The word for beat b is requested during beat b-1, so payload reads start
    // on the last header beat and stop one beat before the end.
    assign rd_en   = busy && (beat >= (len_w + 1)'(hdr_words - 1)) && (beat < last_idx);
    assign rd_addr = rd_ptr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (launch) begin
            rd_ptr <= req.base[ram_addr_w-1:0];
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // =========================================================================
    // Output stage
    // =========================================================================

    always_comb begin
        if (beat == '0) begin
            hdr_word = {frame_tag, req.btype, req.didx};
        end else begin
            hdr_word = word_w'(req.len);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_valid <= 1'b0;
            tx_last  <= 1'b0;
            req.done <= 1'b0;
        end else begin
            tx_valid <= busy;
            tx_last  <= busy && last_beat;
            req.done <= busy && last_beat;  // Same beat as tx_last.
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            tx_data <= (beat < hdr_words) ? hdr_word : rd_data;
        end
    end

endmodule

// ==== hw/tx_buffer_ram.sv ====
`timescale 1ns/10ps

module tx_buffer_ram import com_pkg::*, eth_pkg::*; #(
    parameter int ram_addr_w = addr_w
) (
    input  logic                  clk,

    input  logic                  wr_en,
    input  logic [ram_addr_w-1:0] wr_addr,
    input  logic [word_w-1:0]     wr_data,

    input  logic                  rd_en,
    input  logic [ram_addr_w-1:0] rd_addr,
    output logic [word_w-1:0]     rd_data
);

    logic [word_w-1:0] mem [2**ram_addr_w];

    // Host side.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];  // Data is valid the cycle after rd_en.
        end
    end

endmodule

// ==== hw/com_tx_top.sv ====
`timescale 1ns/10ps

module com_tx_top import com_pkg::*, eth_pkg::*; #(
    parameter int ram_addr_w = addr_w
) (
    input  logic                  clk,
    input  logic                  rst,

    // Host request handshake.
    input  logic                  fs,
    output logic                  fd,
    input  logic [3:0]            btype,
    input  logic [3:0]            didx,
    input  logic [len_w-1:0]      dlen,

    // Region table write port.
    input  logic                  cfg_we,
    input  logic [2:0]            cfg_idx,
    input  logic [addr_w-1:0]     cfg_base,

    // Buffer fill port.
    input  logic                  wr_en,
    input  logic [ram_addr_w-1:0] wr_addr,
    input  logic [word_w-1:0]     wr_data,

    // Output stream, one beat per cycle.
    output logic                  tx_valid,
    output logic [word_w-1:0]     tx_data,
    output logic                  tx_last
);

    logic [addr_w-1:0]     region_base [n_regions];
    logic                  rd_en;
    logic [ram_addr_w-1:0] rd_addr;
    logic [word_w-1:0]     rd_data;

    frame_req_if req_if ();

    send_region_regs u_regions (
        .clk         (clk),
        .rst         (rst),
        .cfg_we      (cfg_we),
        .cfg_idx     (cfg_idx),
        .cfg_base    (cfg_base),
        .region_base (region_base)
    );

    com_send u_send (
        .clk         (clk),
        .rst         (rst),
        .fs          (fs),
        .fd          (fd),
        .btype       (btype),
        .didx        (didx),
        .dlen        (dlen),
        .region_base (region_base),
        .req         (req_if.src)
    );

    eth_frame_tx #(
        .ram_addr_w (ram_addr_w)
    ) u_frame_tx (
        .clk      (clk),
        .rst      (rst),
        .req      (req_if.dst),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_last  (tx_last)
    );

    tx_buffer_ram #(
        .ram_addr_w (ram_addr_w)
    ) u_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// ==== verif/com_tx_assertions.sv ====
`timescale 1ns/10ps

module com_tx_assertions (
    input logic clk,
    input logic rst,
    input logic fs,
    input logic fd,
    input logic tx_valid,
    input logic tx_last
);

    // ========================================================================
    // Handshake and stream properties
    // ========================================================================

    a_last_valid : assert property (@(posedge clk) disable iff (rst)
        tx_last |-> tx_valid)
        else $error("tx_last is high without tx_valid");

    // The host must have released fs before fd may drop.
    a_fd_release : assert property (@(posedge clk) disable iff (rst)
        $fell(fd) |-> !$past(fs))
        else $error("fd fell while fs was still high");

    a_stream_gapless : assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_last) |=> tx_valid)
        else $error("tx_valid dropped inside a frame");

endmodule

bind com_tx_top com_tx_assertions u_assertions (
    .clk      (clk),
    .rst      (rst),
    .fs       (fs),
    .fd       (fd),
    .tx_valid (tx_valid),
    .tx_last  (tx_last)
);

// ==== verif/com_tx_tb.sv ====
`timescale 1ns/10ps

module com_tx_tb import com_pkg::*, eth_pkg::*; ();

    localparam int wait_limit = 200;  // Cycles allowed for any single wait.

    logic              clk = 1'b0;
    logic              rst;
    logic              fs;
    logic              fd;
    logic [3:0]        btype;
    logic [3:0]        didx;
    logic [len_w-1:0]  dlen;
    logic              cfg_we;
    logic [2:0]        cfg_idx;
    logic [addr_w-1:0] cfg_base;
    logic              wr_en;
    logic [addr_w-1:0] wr_addr;
    logic [word_w-1:0] wr_data;
    logic              tx_valid;
    logic [word_w-1:0] tx_data;
    logic              tx_last;

    logic [word_w-1:0] shadow_ram [2**addr_w];
    logic [addr_w-1:0] shadow_region [7] = '{15'h0100, 15'h1000, 15'h2200, 15'h3400,
                                             15'h4600, 15'h5800, 15'h6A00};
    logic [word_w-1:0] exp_beats [$];
    logic [word_w-1:0] got_beats [$];
    string             cur_test;
    int                test_errs;
    int                frames_seen;
    int                pass_count;
    int                fail_count;

    com_tx_top DUT (
        .clk      (clk),
        .rst      (rst),
        .fs       (fs),
        .fd       (fd),
        .btype    (btype),
        .didx     (didx),
        .dlen     (dlen),
        .cfg_we   (cfg_we),
        .cfg_idx  (cfg_idx),
        .cfg_base (cfg_base),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_last  (tx_last)
    );

    always #2 clk = ~clk;

    // ========================================================================
    // Reference model and frame comparison
    // ========================================================================

    // Expected frame: tag word, count word, then count words from the region.
    function automatic void build_expected(input logic [3:0] bt, input logic [3:0] di,
                                           input logic [len_w-1:0] dl);
        logic [addr_w-1:0] base;
        logic [len_w-1:0]  count;
        base  = '0;
        count = '0;
        if (bt == 4'h1) begin
            base  = shadow_region[0];
            count = 13'd14;
        end else if (bt == 4'hE && di <= 4'd5) begin
            base  = shadow_region[di + 1];
            count = dl + 13'd8;
        end
        exp_beats.delete();
        exp_beats.push_back({8'hA5, bt, di});
        exp_beats.push_back({3'b000, count});
        for (int i = 0; i < count; i++) begin
            exp_beats.push_back(shadow_ram[base + i]);
        end
    endfunction

    task automatic compare_frame();
        int n;
        if (got_beats.size() != exp_beats.size()) begin
            $display("ERR %s beat count: expected %0d, actual %0d",
                     cur_test, exp_beats.size(), got_beats.size());
            test_errs++;
        end
        n = (got_beats.size() < exp_beats.size()) ? got_beats.size() : exp_beats.size();
        for (int i = 0; i < n; i++) begin
            if (got_beats[i] !== exp_beats[i]) begin
                $display("ERR %s beat %0d: expected %h, actual %h",
                         cur_test, i, exp_beats[i], got_beats[i]);
                test_errs++;
            end
        end
        got_beats.delete();
        frames_seen++;
    endtask

    always @(negedge clk) begin  // Outputs only change on the rising edge.
        if (tx_valid) begin
            got_beats.push_back(tx_data);
            if (tx_last) begin
                compare_frame();
            end
        end
    end

    // ========================================================================
    // Stimulus tasks
    // ========================================================================

    task automatic fill_words(input logic [addr_w-1:0] base, input int count);
        logic [word_w-1:0] w;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            w        = word_w'($urandom);
            wr_en    = 1'b1;
            wr_addr  = base + addr_w'(i);
            wr_data  = w;
            shadow_ram[base + addr_w'(i)] = w;
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic write_region(input logic [2:0] idx, input logic [addr_w-1:0] base);
        @(negedge clk);
        cfg_we   = 1'b1;
        cfg_idx  = idx;
        cfg_base = base;
        if (idx < 3'd7) begin
            shadow_region[idx] = base;
        end
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("test %-10s ok", name);
        end else begin
            fail_count++;
            $display("test %-10s failed with %0d errors", name, test_errs);
        end
    endtask

    task automatic run_request(input string name, input logic [3:0] bt,
                               input logic [3:0] di, input logic [len_w-1:0] dl);
        int n;
        int latency;
        int hold;
        int frames_before;
        cur_test  = name;
        test_errs = 0;
        build_expected(bt, di, dl);
        frames_before = frames_seen;
        @(negedge clk);
        btype = bt;
        didx  = di;
        dlen  = dl;
        fs    = 1'b1;
        n = 0;
        while (!tx_valid && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        latency = n - 1;  // Counted from the rising edge that first samples fs.
        if (!tx_valid) begin
            $display("%s: no beat came out after fs was raised", name);
            test_errs++;
        end else if (latency != 3) begin
            $display("ERR %s first beat latency: expected %0d, actual %0d",
                     name, 3, latency);
            test_errs++;
        end
        n = 0;
        while (!fd && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!fd) begin
            $display("%s: timed out waiting for fd", name);
            test_errs++;
        end else if (frames_seen != frames_before + 1) begin
            $display("%s: fd rose without exactly one finished frame", name);
            test_errs++;
        end
        hold = $urandom % 3;  // The host may keep fs up a little longer.
        repeat (hold) begin
            @(negedge clk);
            if (!fd) begin
                $display("%s: fd fell while fs was still high", name);
                test_errs++;
            end
        end
        fs = 1'b0;
        n  = 0;
        while (fd && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (fd) begin
            $display("%s: fd stayed high after fs was dropped", name);
            test_errs++;
        end
        report_test(name);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        void'($urandom(32'h2ad3a5e6));
        rst      = 1'b1;
        fs       = 1'b0;
        btype    = '0;
        didx     = '0;
        dlen     = '0;
        cfg_we   = 1'b0;
        cfg_idx  = '0;
        cfg_base = '0;
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        cur_test  = "reset";
        test_errs = 0;
        @(negedge clk);
        if (fd !== 1'b0 || tx_valid !== 1'b0 || tx_last !== 1'b0) begin
            $display("reset: outputs are not idle after reset");
            test_errs++;
        end
        report_test("reset");

        fill_words(shadow_region[0], 14);
        for (int r = 1; r < 7; r++) begin
            fill_words(shadow_region[r], 48);  // Room for the largest data block.
        end

        run_request("info", 4'h1, 4'h0, 13'd0);
        for (int d = 0; d < 6; d++) begin
            run_request($sformatf("data_%0d", d), 4'hE, 4'(d), len_w'($urandom % 41));
        end
        run_request("bad_type", 4'h7, 4'h2, 13'd5);
        run_request("bad_idx6", 4'hE, 4'h6, 13'd3);
        run_request("bad_idx9", 4'hE, 4'h9, 13'd3);

        // New bases for every entry, and a write to the missing entry 7.
        for (int r = 0; r < 7; r++) begin
            write_region(3'(r), addr_w'(($urandom % 28'h6C00) + 28'h0200));
        end
        write_region(3'd7, 15'h7ABC);
        fill_words(shadow_region[0], 14);
        for (int r = 1; r < 7; r++) begin
            fill_words(shadow_region[r], 48);
        end
        run_request("new_info", 4'h1, 4'h0, 13'd0);
        for (int d = 0; d < 6; d++) begin
            run_request($sformatf("new_data_%0d", d), 4'hE, 4'(d), len_w'($urandom % 41));
        end

        for (int k = 0; k < 6; k++) begin
            run_request($sformatf("b2b_%0d", k), (k % 3 == 0) ? 4'h1 : 4'hE,
                        4'($urandom % 6), len_w'($urandom % 41));
        end

        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hw/com_pkg.sv
hw/eth_pkg.sv
hw/frame_req_if.sv
hw/send_region_regs.sv
hw/com_send.sv
hw/eth_frame_tx.sv
hw/tx_buffer_ram.sv
hw/com_tx_top.sv
verif/com_tx_assertions.sv
verif/com_tx_tb.sv

// ==== Bender.yml ====
package:
  name: com_tx

sources:
  - hw/com_pkg.sv
  - hw/eth_pkg.sv
  - hw/frame_req_if.sv
  - hw/send_region_regs.sv
  - hw/com_send.sv
  - hw/eth_frame_tx.sv
  - hw/tx_buffer_ram.sv
  - hw/com_tx_top.sv
  - target: test
    files:
      - verif/com_tx_assertions.sv
      - verif/com_tx_tb.sv
